// ==== logic/bootPkg.sv ====
// Boot loader shared types

package bootPkg;

    // One program word as the processor fetches it
    typedef logic [31:0] instrWord;

    // Program memory address
    typedef logic [7:0] memAddr;

    localparam int memDepth = 256;

    // A word of all ones hands the program over to the processor
    localparam instrWord startCommand = '1;

    // The loader fills a word one byte lane at a time, then judges it whole.
    // Lane 0 holds the first byte received
    typedef union packed {
        logic [3:0][7:0] bytes;
        instrWord        word;
    } loadWord;

endpackage

// ==== logic/uartRx.sv ====
// UART receiver, 8N1

module uartRx #(
    parameter int clksPerBit = 234
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       uartRxd,
    output logic [7:0] rxData,
    output logic       rxStrobe,
    output logic       frameError
);

    localparam int halfBit  = clksPerBit / 2;
    localparam int cntWidth = $clog2(clksPerBit + 1);

    localparam logic [1:0] sIdle  = 2'd0;
    localparam logic [1:0] sStart = 2'd1;
    localparam logic [1:0] sData  = 2'd2;
    localparam logic [1:0] sStop  = 2'd3;

    logic                rxMeta;
    logic                rxSync;
    logic [1:0]          state;
    logic [cntWidth-1:0] bitCnt;
    logic [2:0]          bitIndex;
    logic [7:0]          shiftReg;
    logic                halfDone;
    logic                bitDone;

    // The serial line is asynchronous to clk and idles high
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= uartRxd;
            rxSync <= rxMeta;
        end
    end

    assign halfDone = bitCnt == cntWidth'(halfBit);
    assign bitDone  = bitCnt == cntWidth'(clksPerBit);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= sIdle;
            bitCnt     <= '0;
            bitIndex   <= '0;
            rxStrobe   <= 1'b0;
            frameError <= 1'b0;
        end else begin
            rxStrobe <= 1'b0;
            case (state)
                sIdle: begin
                    if (!rxSync) begin
                        state  <= sStart;
                        bitCnt <= cntWidth'(1);
                    end
                end
                sStart: begin
                    // A line that is high again at mid-start was only a glitch
                    if (halfDone) begin
                        bitCnt   <= cntWidth'(1);
                        bitIndex <= '0;
                        state    <= rxSync ? sIdle : sData;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                sData: begin
                    if (bitDone) begin
                        bitCnt   <= cntWidth'(1);
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7) begin
                            state <= sStop;
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                sStop: begin
                    if (bitDone) begin
                        state  <= sIdle;
                        bitCnt <= '0;
                        if (rxSync) begin
                            rxStrobe <= 1'b1;
                        end else begin
                            frameError <= 1'b1;
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    // LSB arrives first, so bits enter at the top and move down
    always_ff @(posedge clk) begin
        if (state == sData && bitDone) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
    end

    // Stays put from the stop bit until the next frame's first data bit
    assign rxData = shiftReg;

    strobeSingle: assert property (
        @(posedge clk) disable iff (!rstN) rxStrobe |=> !rxStrobe
    ) else $error("rxStrobe held for more than one cycle");

    counterBound: assert property (
        @(posedge clk) disable iff (!rstN) bitCnt <= cntWidth'(clksPerBit)
    ) else $error("bit counter ran past clksPerBit");

endmodule

// ==== logic/programLoader.sv ====
// Program loader

module programLoader (
    input  logic              clk,
    input  logic              rstN,
    input  logic [7:0]        rxData,
    input  logic              rxStrobe,
    output logic              wrEn,
    output bootPkg::memAddr   wrAddr,
    output bootPkg::instrWord wrData,
    output logic [5:0]        led,
    output logic              cpuEnable
);

    import bootPkg::*;

    loadWord    assembly;
    loadWord    nextWord;
    logic [1:0] lane;
    logic       accept;
    logic       lastLane;
    logic       isStart;

    // Loading is over for good once the processor runs
    assign accept   = rxStrobe && !cpuEnable;
    assign lastLane = lane == 2'd3;

    // The incoming byte merged into its lane
    always_comb begin
        nextWord             = assembly;
        nextWord.bytes[lane] = rxData;
    end

    assign isStart = nextWord.word == startCommand;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lane      <= '0;
            wrEn      <= 1'b0;
            wrAddr    <= '0;
            cpuEnable <= 1'b0;
        end else begin
            wrEn <= 1'b0;
            // The write lands on this edge, so move to the next slot
            if (wrEn) begin
                wrAddr <= wrAddr + 1'b1;
            end
            if (accept) begin
                lane <= lane + 1'b1;
                if (lastLane) begin
                    if (isStart) begin
                        cpuEnable <= 1'b1;
                    end else begin
                        wrEn <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            assembly <= nextWord;
        end
    end

    // The word register is complete while wrEn is high
    assign wrData = assembly.word;

    // LEDs are active low and keep following the line after the start command
    always_ff @(posedge clk) begin
        if (!rstN) begin
            led <= '1;
        end else if (rxStrobe) begin
            led <= ~rxData[5:0];
        end
    end

    noWriteAfterStart: assert property (
        @(posedge clk) disable iff (!rstN) !(wrEn && cpuEnable)
    ) else $error("memory write while the processor is enabled");

    enableSticky: assert property (
        @(posedge clk) (cpuEnable && rstN) |=> cpuEnable
    ) else $error("cpuEnable dropped without a reset");

endmodule

// ==== logic/programMemory.sv ====
// Program memory

module programMemory (
    input  logic              clk,
    input  logic              wrEn,
    input  bootPkg::memAddr   wrAddr,
    input  bootPkg::instrWord wrData,
    input  bootPkg::memAddr   fetchAddr,
    output bootPkg::instrWord fetchData
);

    import bootPkg::*;

    instrWord mem [memDepth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // The registered read returns old data on a same-address write
    always_ff @(posedge clk) begin
        fetchData <= mem[fetchAddr];
    end

endmodule

// ==== logic/bootLoaderTop.sv ====
// Serial boot loader top

module bootLoaderTop #(
    // 27 MHz clock at 115200 baud
    parameter int clksPerBit = 234
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              uartRxd,
    output logic [5:0]        led,
    output logic              cpuEnable,
    output logic              frameError,
    input  bootPkg::memAddr   fetchAddr,
    output bootPkg::instrWord fetchData
);

    import bootPkg::*;

    logic [7:0] rxData;
    logic       rxStrobe;
    logic       wrEn;
    memAddr     wrAddr;
    instrWord   wrData;

    uartRx #(
        .clksPerBit(clksPerBit)
    ) uartRx_i (
        .clk       (clk),
        .rstN      (rstN),
        .uartRxd   (uartRxd),
        .rxData    (rxData),
        .rxStrobe  (rxStrobe),
        .frameError(frameError)
    );

    programLoader programLoader_i (
        .clk      (clk),
        .rstN     (rstN),
        .rxData   (rxData),
        .rxStrobe (rxStrobe),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .led      (led),
        .cpuEnable(cpuEnable)
    );

    programMemory programMemory_i (
        .clk      (clk),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .fetchAddr(fetchAddr),
        .fetchData(fetchData)
    );

endmodule

// ==== tests/bootLoaderTb.sv ====
// Serial boot loader testbench

module bootLoaderTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clksPerBit = 8;
    localparam int tokenBits = 8 * 32;
    localparam int lineBits = 8 * 128;
    localparam string tracePath = "tests/bootTrace.txt";

    logic        clk;
    logic        rstN;
    logic        uartRxd;
    logic [5:0]  led;
    logic        cpuEnable;
    logic        frameError;
    logic [7:0]  fetchAddr;
    logic [31:0] fetchData;

    int                    fd;
    int                    lineCount;
    int                    cycleCount = 0;
    int                    cycleLimit = 0;
    logic [tokenBits-1:0]  token;
    logic [tokenBits-1:0]  testName;
    logic [lineBits-1:0]   lineBuf;

    bootLoaderTop #(
        .clksPerBit(clksPerBit)
    ) bootLoaderTop_i (
        .clk       (clk),
        .rstN      (rstN),
        .uartRxd   (uartRxd),
        .led       (led),
        .cpuEnable (cpuEnable),
        .frameError(frameError),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%0s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compareValue(input logic [31:0] expected, input logic [31:0] actual,
                                input string what);
        if (actual !== expected) begin
            reportFailure($sformatf("[FAIL] %0s: %0s expected %h, got %h",
                                    testName, what, expected, actual));
        end
    endtask

    // Trace lines hold single letters, stored right aligned in the token
    function automatic logic tokenIs(input logic [7:0] letter);
        return token[tokenBits-1:8] == '0 && token[7:0] == letter;
    endfunction

    task automatic readHex(output logic [31:0] value);
        value = '0;
        if ($fscanf(fd, "%h", value) != 1) begin
            reportFailure("the trace file has a command with a missing operand");
        end
    endtask

    task automatic holdBit();
        repeat (clksPerBit) @(negedge clk);
    endtask

    // Start bit, eight data bits LSB first, stop bit, then an idle gap
    task automatic sendFrame(input logic [7:0] value, input logic stopLevel);
        int gapBits;
        gapBits = $urandom_range(3, 0);
        uartRxd = 1'b0;
        holdBit();
        for (int i = 0; i < 8; i++) begin
            uartRxd = value[i];
            holdBit();
        end
        uartRxd = stopLevel;
        holdBit();
        uartRxd = 1'b1;
        repeat ((1 + gapBits) * clksPerBit) @(negedge clk);
    endtask

    // A low pulse well under half a bit, followed by a quiet frame time
    task automatic sendGlitch();
        uartRxd = 1'b0;
        repeat (clksPerBit / 4) @(negedge clk);
        uartRxd = 1'b1;
        repeat (10 * clksPerBit) @(negedge clk);
    endtask

    task automatic readWord(input logic [7:0] addr, input logic [31:0] expected);
        fetchAddr = addr;
        @(negedge clk);
        compareValue(expected, fetchData, $sformatf("fetchData at %h", addr));
    endtask

    task automatic runCommand();
        logic [31:0] argA;
        logic [31:0] argB;
        if (tokenIs("#")) begin
            void'($fgets(lineBuf, fd));
        end else if (tokenIs("T")) begin
            testName = '0;
            if ($fscanf(fd, "%s", testName) != 1) begin
                reportFailure("the trace file has a test line without a name");
            end
        end else if (tokenIs("B")) begin
            readHex(argA);
            sendFrame(argA[7:0], 1'b1);
        end else if (tokenIs("E")) begin
            readHex(argA);
            sendFrame(argA[7:0], 1'b0);
        end else if (tokenIs("G")) begin
            sendGlitch();
        end else if (tokenIs("L")) begin
            readHex(argA);
            compareValue(argA, {26'b0, led}, "led");
        end else if (tokenIs("F")) begin
            readHex(argA);
            compareValue(argA, {31'b0, frameError}, "frameError");
        end else if (tokenIs("C")) begin
            readHex(argA);
            compareValue(argA, {31'b0, cpuEnable}, "cpuEnable");
        end else if (tokenIs("R")) begin
            readHex(argA);
            readHex(argB);
            readWord(argA[7:0], argB);
        end else begin
            reportFailure($sformatf("the trace file has an unknown command %0s", token));
        end
    endtask

    // The run limit scales with the trace since a line never takes more than 14 bit times
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            reportFailure($sformatf("timeout, the run went past %0d cycles", cycleLimit));
        end
    end

    initial begin
        rstN = 1'b0;
        uartRxd = 1'b1;
        fetchAddr = '0;
        testName = '0;
        void'($urandom(32'h07eb04d9));

        fd = $fopen(tracePath, "r");
        if (fd == 0) begin
            reportFailure("could not open the trace file");
        end
        lineCount = 0;
        while ($fgets(lineBuf, fd) != 0) begin
            lineCount++;
        end
        $fclose(fd);
        cycleLimit = lineCount * 14 * clksPerBit + 200;

        fd = $fopen(tracePath, "r");
        if (fd == 0) begin
            reportFailure("could not reopen the trace file");
        end

        repeat (2) @(negedge clk);
        rstN = 1'b1;
        repeat (2) @(negedge clk);

        token = '0;
        while ($fscanf(fd, "%s", token) == 1) begin
            runCommand();
            token = '0;
        end
        $fclose(fd);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tests/bootTrace.txt ====
# Commands: T name, B byte, E byte with low stop bit, G start glitch, L leds,
# F frameError, C cpuEnable, R address word. All values are hex
T reset
L 3F
F 0
C 0
T loadTwoWords
B 13
L 2C
B 57
L 28
B 9B
L 24
B DF
L 20
B 2A
L 15
B 01
L 3E
B C4
B 6E
L 11
C 0
R 00 DF9B5713
R 01 6EC4012A
T frameError
E A5
F 1
L 11
B 40
B 31
B 22
B 13
L 2C
R 02 13223140
T startGlitch
B 8C
G
B 75
B 0F
B E6
L 19
F 1
R 03 E60F758C
T startCommand
B FF
B FF
B FF
B FF
C 1
L 00
B 5A
L 25
B 12
B 34
B 56
L 29
C 1
R 00 DF9B5713
R 01 6EC4012A
R 02 13223140
R 03 E60F758C

// ==== list.f ====
logic/bootPkg.sv
logic/uartRx.sv
logic/programLoader.sv
logic/programMemory.sv
logic/bootLoaderTop.sv
tests/bootLoaderTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the boot loader testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

buildDir=build
simName=bootLoaderSim
logFile=sim.log

verilator --binary --timing --assert -sv \
    --timescale 1ns/100ps \
    --top-module bootLoaderTb \
    -Mdir "$buildDir" -o "$simName" \
    -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "=== FAIL ===" "$logFile"; then
    exit 1
fi

exit 0
